// File: common/obs_pkg.sv
/*
 * Observed side of the controller monitor.
 * Controller observation struct, PC source encoding,
 * data bus request and response samples, bus error record
 * and the outstanding transaction depth.
 */
package obs_pkg;

  // Number of data bus transactions that may be in flight at once
  localparam int unsigned MAX_OUTSTANDING = 2;

  // Width of the outstanding counter, wide enough to hold MAX_OUTSTANDING
  localparam int unsigned OUTST_CNT_W = $clog2(MAX_OUTSTANDING + 1);

  typedef logic [OUTST_CNT_W-1:0] outst_cnt_t;

  // Source of a program counter update
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_DRET     = 3'd4,
    PC_TRAP_EXC = 3'd5,
    PC_TRAP_NMI = 3'd6
  } pc_mux_e;

  // One cycle of controller observation, 13 bits in total
  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
    logic    csr_we_wb;
    logic    fencei_in_wb;
    logic    fencei_req;
    logic    fencei_ack;
    logic    wb_valid;
    logic    irq_ack;
    logic    debug_mode;
    logic    nmi_pending;
    logic    nmi_is_store;
  } ctrl_obs_t;

  // Data bus request sample, we is only meaningful on an accepted cycle
  typedef struct packed {
    logic req;
    logic gnt;
    logic we;
  } obi_req_t;

  // Data bus response sample
  typedef struct packed {
    logic rvalid;
    logic err;
  } obi_resp_t;

  // First bus error as seen by the NMI retire checker
  typedef struct packed {
    logic latched;
    logic is_write;
    logic retire_at_error;
    logic first;
  } bus_err_info_t;

endpackage

// File: common/mon_pkg.sv
/*
 * Reported side of the controller monitor.
 * Violation indices, violation vector and NMI retire limits.
 */
package mon_pkg;

  // Violation indices, also the bit positions in viol_vec_t
  typedef enum logic [3:0] {
    V_BRANCH_B2B         = 4'd0,
    V_JUMP_B2B           = 4'd1,
    V_XRET_CSR           = 4'd2,
    V_FENCEI_NO_INSTR    = 4'd3,
    V_FENCEI_EARLY_CLEAR = 4'd4,
    V_FENCEI_HOLD        = 4'd5,
    V_FENCEI_NO_RETIRE   = 4'd6,
    V_IRQ_OUTSTANDING    = 4'd7,
    V_OBI_OVERFLOW       = 4'd8,
    V_NMI_TYPE           = 4'd9,
    V_NMI_LATE           = 4'd10
  } viol_e;

  localparam int unsigned N_VIOL = 11;

  // One bit per violation index
  typedef logic [N_VIOL-1:0] viol_vec_t;

  // Retirement count at which the bus error NMI is considered late
  // The lower limit applies when an instruction retired with the error
  localparam int unsigned NMI_RETIRE_LIMIT_HIT  = 2;
  localparam int unsigned NMI_RETIRE_LIMIT_MISS = 3;

  localparam int unsigned RETIRE_CNT_W = $clog2(NMI_RETIRE_LIMIT_MISS + 1);

  typedef logic [RETIRE_CNT_W-1:0] retire_cnt_t;

endpackage

// File: source/pc_seq_check.sv
/*
 * Program counter sequencing checker.
 * Flags back to back branches, back to back jumps and
 * an xRET that coincides with a CSR write in writeback.
 */
`timescale 1ns/1ps

module pc_seq_check (
  input  logic               clk,
  input  logic               rst_n,
  input  obs_pkg::ctrl_obs_t obs_i,
  output mon_pkg::viol_vec_t viol_o
);

  logic branch_now;
  logic jump_now;
  logic xret_now;
  logic branch_q;
  logic jump_q;

  // A taken branch redirects the PC from the branch target
  assign branch_now = obs_i.pc_set && (obs_i.pc_mux == obs_pkg::PC_BRANCH);

  // MRET is grouped with jumps since both redirect from the ID stage
  assign jump_now = obs_i.pc_set &&
                    ((obs_i.pc_mux == obs_pkg::PC_JUMP) || (obs_i.pc_mux == obs_pkg::PC_MRET));

  // Both return flavours read CSRs that must not be written at the same time
  assign xret_now = obs_i.pc_set &&
                    ((obs_i.pc_mux == obs_pkg::PC_MRET) || (obs_i.pc_mux == obs_pkg::PC_DRET));

  // History of the previous cycle's PC update
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      branch_q <= 1'b0;
      jump_q   <= 1'b0;
    end else begin
      branch_q <= branch_now;
      jump_q   <= jump_now;
    end
  end

  // Pulses only touch this checker's own bits
  always_comb begin
    viol_o                           = '0;
    viol_o[mon_pkg::V_BRANCH_B2B]    = branch_q && branch_now;
    viol_o[mon_pkg::V_JUMP_B2B]      = jump_q && jump_now;
    viol_o[mon_pkg::V_XRET_CSR]      = xret_now && obs_i.csr_we_wb;
  end

endmodule

// File: source/fencei_check.sv
/*
 * Fence flush handshake checker.
 * Watches the flush request against the fence in writeback,
 * the acknowledge and the retirement that ends the fence.
 */
`timescale 1ns/1ps

module fencei_check (
  input  logic               clk,
  input  logic               rst_n,
  input  obs_pkg::ctrl_obs_t obs_i,
  output mon_pkg::viol_vec_t viol_o
);

  logic req_q;
  logic req_ack_q;
  logic req_fell;

  ////////////////////////////////////////////////////////////
  // Handshake history
  ////////////////////////////////////////////////////////////

  // Previous request level and whether the handshake completed last cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q     <= 1'b0;
      req_ack_q <= 1'b0;
    end else begin
      req_q     <= obs_i.fencei_req;
      req_ack_q <= obs_i.fencei_req && obs_i.fencei_ack;
    end
  end

  // Falling edge of the request, the end of a flush handshake
  assign req_fell = req_q && !obs_i.fencei_req;

  ////////////////////////////////////////////////////////////
  // Violation pulses
  ////////////////////////////////////////////////////////////

  always_comb begin
    viol_o = '0;

    // A request may only be raised on behalf of a fence in writeback
    viol_o[mon_pkg::V_FENCEI_NO_INSTR] = obs_i.fencei_req && !obs_i.fencei_in_wb;

    // The request has to drop in the cycle right after req and ack met
    viol_o[mon_pkg::V_FENCEI_HOLD] = req_ack_q && obs_i.fencei_req;

    // Since req_fell implies req_q, a missing req_ack_q means no ack last cycle
    viol_o[mon_pkg::V_FENCEI_EARLY_CLEAR] = req_fell && !req_ack_q;

    // The fence retires in the cycle the request drops
    viol_o[mon_pkg::V_FENCEI_NO_RETIRE] = req_fell && !obs_i.wb_valid;
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // Request history starts cleared, so no falling edge right after reset
  a_no_fell_after_reset :
    assert property (@(posedge clk) $rose(rst_n) |-> !req_fell)
      else $error("fencei_check: falling request seen in first cycle after reset");

endmodule

// File: bus_err/bus_err_tracker.sv
/*
 * Data bus outstanding transaction tracker.
 * Keeps the count and write flags of transactions in flight,
 * latches the first bus error and flags interrupt acknowledge
 * with outstanding transactions and outstanding overflow.
 */
`timescale 1ns/1ps

module bus_err_tracker (
  input  logic                   clk,
  input  logic                   rst_n,
  input  obs_pkg::ctrl_obs_t     obs_i,
  input  obs_pkg::obi_req_t      bus_req_i,
  input  obs_pkg::obi_resp_t     bus_resp_i,
  output obs_pkg::bus_err_info_t err_o,
  output mon_pkg::viol_vec_t     viol_o
);

  obs_pkg::outst_cnt_t                cnt_q;
  logic [obs_pkg::MAX_OUTSTANDING-1:0] wtype_q;
  logic                               accept;
  logic                               resp;
  logic                               at_max;
  logic                               oldest_we;
  logic                               err_first;
  logic                               nmi_taken;
  logic                               latched_q;
  logic                               is_write_q;
  logic                               retire_at_error_q;

  assign accept = bus_req_i.req && bus_req_i.gnt;
  assign resp   = bus_resp_i.rvalid;
  assign at_max = cnt_q == obs_pkg::outst_cnt_t'(obs_pkg::MAX_OUTSTANDING);

  // Index 0 holds the newest transaction, so the oldest sits at count minus one
  assign oldest_we = (cnt_q > obs_pkg::outst_cnt_t'(1)) ? wtype_q[1] : wtype_q[0];

  // Only the first erroneous response is recorded until the NMI is taken
  assign err_first = resp && bus_resp_i.err && !latched_q;
  assign nmi_taken = obs_i.pc_set && (obs_i.pc_mux == obs_pkg::PC_TRAP_NMI);

  ////////////////////////////////////////////////////////////
  // Outstanding count and write flags
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q   <= '0;
      wtype_q <= '0;
    end else if (accept && !resp) begin
      // New transaction shifts in, count saturates at the bus depth
      if (!at_max) begin
        cnt_q   <= cnt_q + obs_pkg::outst_cnt_t'(1);
        wtype_q <= {wtype_q[obs_pkg::MAX_OUTSTANDING-2:0], bus_req_i.we};
      end
    end else if (!accept && resp) begin
      if (cnt_q != '0) begin
        cnt_q <= cnt_q - obs_pkg::outst_cnt_t'(1);
      end
    end else if (accept && resp) begin
      // Oldest completes while a new one enters, count is unchanged
      if (at_max) begin
        wtype_q <= {wtype_q[obs_pkg::MAX_OUTSTANDING-2:0], bus_req_i.we};
      end else begin
        wtype_q[0] <= bus_req_i.we;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // First bus error latch
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      latched_q         <= 1'b0;
      is_write_q        <= 1'b0;
      retire_at_error_q <= 1'b0;
    end else if (err_first) begin
      latched_q         <= 1'b1;
      is_write_q        <= oldest_we;
      retire_at_error_q <= obs_i.wb_valid;
    end else if (nmi_taken) begin
      latched_q <= 1'b0;
    end
  end

  // The first flag marks the cycle in which the latch is loaded
  assign err_o = '{latched:         latched_q,
                   is_write:        is_write_q,
                   retire_at_error: retire_at_error_q,
                   first:           err_first};

  always_comb begin
    viol_o                              = '0;
    viol_o[mon_pkg::V_IRQ_OUTSTANDING]  = obs_i.irq_ack && (cnt_q != '0);
    viol_o[mon_pkg::V_OBI_OVERFLOW]     = accept && !resp && at_max;
  end

  // Holds across any mix of accepts and responses over time
  a_cnt_bound :
    assert property (@(posedge clk) disable iff (!rst_n)
                     cnt_q <= obs_pkg::outst_cnt_t'(obs_pkg::MAX_OUTSTANDING))
      else $error("bus_err_tracker: outstanding count above bus depth");

endmodule

// File: bus_err/nmi_retire_check.sv
/*
 * Bus error NMI checker.
 * Checks the pending NMI type after a latched bus error and
 * bounds the retirements before the NMI is taken.
 */
`timescale 1ns/1ps

module nmi_retire_check (
  input  logic                   clk,
  input  logic                   rst_n,
  input  obs_pkg::ctrl_obs_t     obs_i,
  input  obs_pkg::bus_err_info_t err_i,
  output mon_pkg::viol_vec_t     viol_o
);

  logic                 first_q;
  logic                 retire;
  logic                 type_ok;
  mon_pkg::retire_cnt_t cnt_q;
  mon_pkg::retire_cnt_t limit;

  // One extra retirement is allowed when none retired together with the error
  assign limit = err_i.retire_at_error ?
                 mon_pkg::retire_cnt_t'(mon_pkg::NMI_RETIRE_LIMIT_HIT) :
                 mon_pkg::retire_cnt_t'(mon_pkg::NMI_RETIRE_LIMIT_MISS);

  // Retirements in debug mode do not count toward the bound
  assign retire = obs_i.wb_valid && !obs_i.debug_mode;

  // The controller must show a pending NMI of the latched access type
  assign type_ok = obs_i.nmi_pending && (obs_i.nmi_is_store == err_i.is_write);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_q <= 1'b0;
      cnt_q   <= '0;
    end else begin
      first_q <= err_i.first;
      // Counting starts the cycle after the latch, saturating at the limit
      if (!err_i.latched) begin
        cnt_q <= '0;
      end else if (retire && (cnt_q != limit)) begin
        cnt_q <= cnt_q + mon_pkg::retire_cnt_t'(1);
      end
    end
  end

  always_comb begin
    viol_o                       = '0;
    viol_o[mon_pkg::V_NMI_TYPE]  = first_q && !type_ok;
    viol_o[mon_pkg::V_NMI_LATE]  = err_i.latched && (cnt_q == limit);
  end

endmodule

// File: source/viol_log.sv
/*
 * Violation log.
 * Enable masked sticky violation flags and first violation record.
 */
`timescale 1ns/1ps

module viol_log (
  input  logic               clk,
  input  logic               rst_n,
  input  mon_pkg::viol_vec_t viol_i,
  input  mon_pkg::viol_vec_t en_mask_i,
  input  logic               clear_i,
  output mon_pkg::viol_vec_t viol_flags_o,
  output mon_pkg::viol_e     first_viol_o,
  output logic               first_viol_valid_o
);

  mon_pkg::viol_vec_t masked;
  mon_pkg::viol_e     low_idx;
  logic               record;

  assign masked = viol_i & en_mask_i;

  // Lowest set index wins when several violations hit in one cycle
  always_comb begin
    low_idx = mon_pkg::V_BRANCH_B2B;
    for (int i = mon_pkg::N_VIOL - 1; i >= 0; i--) begin
      if (masked[i]) begin
        low_idx = mon_pkg::viol_e'(i);
      end
    end
  end

  // A clear in the same cycle drops any new violation
  assign record = !clear_i && !first_viol_valid_o && (|masked);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      viol_flags_o       <= '0;
      first_viol_valid_o <= 1'b0;
    end else if (clear_i) begin
      viol_flags_o       <= '0;
      first_viol_valid_o <= 1'b0;
    end else begin
      viol_flags_o <= viol_flags_o | masked;
      if (record) begin
        first_viol_valid_o <= 1'b1;
      end
    end
  end

  // Code is only meaningful while first_viol_valid_o is high
  always_ff @(posedge clk) begin
    if (record) begin
      first_viol_o <= low_idx;
    end
  end

  a_first_stable :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (first_viol_valid_o && $past(first_viol_valid_o)) |-> $stable(first_viol_o))
      else $error("viol_log: first violation code changed while valid");

endmodule

// File: source/ctrl_monitor_top.sv
/*
 * Controller run time monitor top level.
 * Fans the observation out to the checkers and ORs their
 * violation pulses into the violation log.
 */
`timescale 1ns/1ps

module ctrl_monitor_top (
  input  logic               clk,
  input  logic               rst_n,
  input  obs_pkg::ctrl_obs_t obs_i,
  input  obs_pkg::obi_req_t  bus_req_i,
  input  obs_pkg::obi_resp_t bus_resp_i,
  input  mon_pkg::viol_vec_t en_mask_i,
  input  logic               clear_i,
  output mon_pkg::viol_vec_t viol_flags_o,
  output mon_pkg::viol_e     first_viol_o,
  output logic               first_viol_valid_o
);

  mon_pkg::viol_vec_t     viol_pc;
  mon_pkg::viol_vec_t     viol_fencei;
  mon_pkg::viol_vec_t     viol_bus;
  mon_pkg::viol_vec_t     viol_nmi;
  mon_pkg::viol_vec_t     viol_all;
  obs_pkg::bus_err_info_t bus_err;

  ////////////////////////////////////////////////////////////
  // Checkers
  ////////////////////////////////////////////////////////////

  pc_seq_check u_pc_seq_check (
    .clk    (clk),
    .rst_n  (rst_n),
    .obs_i  (obs_i),
    .viol_o (viol_pc)
  );

  fencei_check u_fencei_check (
    .clk    (clk),
    .rst_n  (rst_n),
    .obs_i  (obs_i),
    .viol_o (viol_fencei)
  );

  bus_err_tracker u_bus_err_tracker (
    .clk        (clk),
    .rst_n      (rst_n),
    .obs_i      (obs_i),
    .bus_req_i  (bus_req_i),
    .bus_resp_i (bus_resp_i),
    .err_o      (bus_err),
    .viol_o     (viol_bus)
  );

  // Consumes the bus error record kept by the tracker
  nmi_retire_check u_nmi_retire_check (
    .clk    (clk),
    .rst_n  (rst_n),
    .obs_i  (obs_i),
    .err_i  (bus_err),
    .viol_o (viol_nmi)
  );

  ////////////////////////////////////////////////////////////
  // Log
  ////////////////////////////////////////////////////////////

  // Each checker drives only its own bits, so OR merges without conflict
  assign viol_all = viol_pc | viol_fencei | viol_bus | viol_nmi;

  viol_log u_viol_log (
    .clk                (clk),
    .rst_n              (rst_n),
    .viol_i             (viol_all),
    .en_mask_i          (en_mask_i),
    .clear_i            (clear_i),
    .viol_flags_o       (viol_flags_o),
    .first_viol_o       (first_viol_o),
    .first_viol_valid_o (first_viol_valid_o)
  );

endmodule

// File: tests/tb_checker.sv
/*
 * Result checker for the controller monitor testbench.
 * Compares the sticky flags and the first violation record
 * with the expected flags at the end of every test.
 */
`timescale 1ns/1ps

module tb_checker (
  input  logic               clk,
  input  logic               check_req_i,
  input  logic [7:0]         test_id_i,
  input  mon_pkg::viol_vec_t exp_flags_i,
  input  mon_pkg::viol_vec_t flags_i,
  input  mon_pkg::viol_e     first_i,
  input  logic               first_valid_i,
  output logic               check_done_o,
  output int                 pass_cnt_o,
  output int                 fail_cnt_o
);

  localparam int SETTLE_LIMIT = 4;
  localparam int IDLE_LIMIT   = 64;

  // The lowest index among the expected flags is recorded first
  function automatic mon_pkg::viol_e lowest_viol(input mon_pkg::viol_vec_t v);
    mon_pkg::viol_e idx;
    logic           found;
    idx   = mon_pkg::V_BRANCH_B2B;
    found = 1'b0;
    for (int i = 0; i < mon_pkg::N_VIOL; i++) begin
      if (v[i] && !found) begin
        idx   = mon_pkg::viol_e'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  // Requests are sampled on the rising edge, flags on the falling edge
  initial begin
    int                 waits;
    logic               ok;
    mon_pkg::viol_vec_t exp;
    check_done_o = 1'b0;
    pass_cnt_o   = 0;
    fail_cnt_o   = 0;
    forever begin
      waits = 0;
      @(posedge clk);
      while (!check_req_i && waits < IDLE_LIMIT) begin
        @(posedge clk);
        waits++;
      end
      if (!check_req_i) begin
        $display("No end of test request arrived within %0d cycles", IDLE_LIMIT);
        fail_cnt_o++;
      end else begin
        exp   = exp_flags_i;
        ok    = 1'b1;
        waits = 0;
        @(negedge clk);
        while (flags_i !== exp && waits < SETTLE_LIMIT) begin
          @(negedge clk);
          waits++;
        end
        if (flags_i !== exp) begin
          $display("ERROR %0t: test %0d flags %h, expected %h", $time, test_id_i, flags_i, exp);
          ok = 1'b0;
        end
        if (first_valid_i !== (|exp)) begin
          $display("ERROR %0t: test %0d first valid %b, expected %b",
                   $time, test_id_i, first_valid_i, |exp);
          ok = 1'b0;
        end else if (first_valid_i && first_i !== lowest_viol(exp)) begin
          $display("ERROR %0t: test %0d first code %0d, expected %0d",
                   $time, test_id_i, first_i, lowest_viol(exp));
          ok = 1'b0;
        end
        if (ok) begin
          $display("Test %0d passed", test_id_i);
          pass_cnt_o++;
        end else begin
          $display("Test %0d failed", test_id_i);
          fail_cnt_o++;
        end
        check_done_o = 1'b1;
        // Hold done until the drive loop drops its request
        waits = 0;
        while (check_req_i && waits < IDLE_LIMIT) begin
          @(posedge clk);
          waits++;
        end
        @(negedge clk);
        check_done_o = 1'b0;
      end
    end
  end

endmodule

// File: tests/tb_top.sv
/*
 * Testbench top for the controller run time monitor.
 * Clock and reset, the stimulus table with expected flags,
 * the DUT instance, the drive loop and the final verdict.
 */
`timescale 1ns/1ps

module tb_top;

  // One table row
  // The expected flags are read on the end of test row only
  typedef struct packed {
    obs_pkg::ctrl_obs_t obs;
    obs_pkg::obi_req_t  req;
    obs_pkg::obi_resp_t resp;
    mon_pkg::viol_vec_t en_mask;
    logic               clear;
    logic [7:0]         test_id;
    logic               last;
    mon_pkg::viol_vec_t exp;
  } stim_row_t;

  // Cycles the drive loop waits for the checker to answer
  localparam int DONE_LIMIT = 16;

  localparam obs_pkg::obi_req_t  NO_REQ  = 3'b000;
  localparam obs_pkg::obi_req_t  ACC_RD  = 3'b110;
  localparam obs_pkg::obi_req_t  ACC_WR  = 3'b111;
  localparam obs_pkg::obi_resp_t NO_RSP  = 2'b00;
  localparam obs_pkg::obi_resp_t RSP_OK  = 2'b10;
  localparam obs_pkg::obi_resp_t RSP_ERR = 2'b11;

  logic               clk;
  logic               rst_n;
  obs_pkg::ctrl_obs_t obs;
  obs_pkg::obi_req_t  bus_req;
  obs_pkg::obi_resp_t bus_resp;
  mon_pkg::viol_vec_t en_mask;
  logic               clear;
  mon_pkg::viol_vec_t viol_flags;
  mon_pkg::viol_e     first_viol;
  logic               first_viol_valid;

  logic               check_req;
  logic [7:0]         check_id;
  mon_pkg::viol_vec_t check_exp;
  logic               check_done;
  int                 pass_cnt;
  int                 fail_cnt;

  stim_row_t          stim_q[$];
  logic [7:0]         cur_id;
  mon_pkg::viol_vec_t cur_mask;
  int                 n_tests;
  logic               timed_out;

  always #2 clk = ~clk;

  ctrl_monitor_top UUT (
    .clk                (clk),
    .rst_n              (rst_n),
    .obs_i              (obs),
    .bus_req_i          (bus_req),
    .bus_resp_i         (bus_resp),
    .en_mask_i          (en_mask),
    .clear_i            (clear),
    .viol_flags_o       (viol_flags),
    .first_viol_o       (first_viol),
    .first_viol_valid_o (first_viol_valid)
  );

  tb_checker u_checker (
    .clk           (clk),
    .check_req_i   (check_req),
    .test_id_i     (check_id),
    .exp_flags_i   (check_exp),
    .flags_i       (viol_flags),
    .first_i       (first_viol),
    .first_valid_i (first_viol_valid),
    .check_done_o  (check_done),
    .pass_cnt_o    (pass_cnt),
    .fail_cnt_o    (fail_cnt)
  );

  ////////////////////////////////////////////////////////////
  // Row builders
  ////////////////////////////////////////////////////////////

  function automatic mon_pkg::viol_vec_t viol_bit(input mon_pkg::viol_e v);
    mon_pkg::viol_vec_t m;
    m    = '0;
    m[v] = 1'b1;
    return m;
  endfunction

  function automatic obs_pkg::ctrl_obs_t pc_update(input obs_pkg::pc_mux_e mux);
    obs_pkg::ctrl_obs_t o;
    o        = '0;
    o.pc_set = 1'b1;
    o.pc_mux = mux;
    return o;
  endfunction

  function automatic obs_pkg::ctrl_obs_t fence_state(input logic in_wb, input logic req,
                                                     input logic ack);
    obs_pkg::ctrl_obs_t o;
    o              = '0;
    o.fencei_in_wb = in_wb;
    o.fencei_req   = req;
    o.fencei_ack   = ack;
    return o;
  endfunction

  function automatic obs_pkg::ctrl_obs_t retire_obs();
    obs_pkg::ctrl_obs_t o;
    o          = '0;
    o.wb_valid = 1'b1;
    return o;
  endfunction

  task automatic add_row(input obs_pkg::ctrl_obs_t o, input obs_pkg::obi_req_t rq,
                         input obs_pkg::obi_resp_t rs);
    stim_row_t r;
    r         = '0;
    r.obs     = o;
    r.req     = rq;
    r.resp    = rs;
    r.en_mask = cur_mask;
    r.test_id = cur_id;
    stim_q.push_back(r);
  endtask

  task automatic clear_row();
    stim_row_t r;
    r         = '0;
    r.en_mask = cur_mask;
    r.clear   = 1'b1;
    r.test_id = cur_id;
    stim_q.push_back(r);
  endtask

  // Every test opens with a clear so flags and the first code start empty
  task automatic begin_test(input logic [7:0] id, input mon_pkg::viol_vec_t mask);
    cur_id   = id;
    cur_mask = mask;
    clear_row();
  endtask

  // Idle closing row that carries the flags expected at the end of the test
  task automatic end_test(input mon_pkg::viol_vec_t exp);
    stim_row_t r;
    r         = '0;
    r.en_mask = cur_mask;
    r.test_id = cur_id;
    r.last    = 1'b1;
    r.exp     = exp;
    stim_q.push_back(r);
    n_tests++;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  task automatic build_table();
    obs_pkg::ctrl_obs_t o;
    // Branch after branch, branch then jump, MRET during a CSR write
    begin_test(8'd1, '1);
    add_row(pc_update(obs_pkg::PC_BRANCH), NO_REQ, NO_RSP);
    add_row(pc_update(obs_pkg::PC_BRANCH), NO_REQ, NO_RSP);
    end_test(viol_bit(mon_pkg::V_BRANCH_B2B));
    begin_test(8'd2, '1);
    add_row(pc_update(obs_pkg::PC_BRANCH), NO_REQ, NO_RSP);
    add_row(pc_update(obs_pkg::PC_JUMP), NO_REQ, NO_RSP);
    end_test('0);
    begin_test(8'd3, '1);
    o           = pc_update(obs_pkg::PC_MRET);
    o.csr_we_wb = 1'b1;
    add_row(o, NO_REQ, NO_RSP);
    end_test(viol_bit(mon_pkg::V_XRET_CSR));
    // Legal fence handshake, then each fence fault on its own
    begin_test(8'd4, '1);
    add_row(fence_state(1'b1, 1'b1, 1'b0), NO_REQ, NO_RSP);
    add_row(fence_state(1'b1, 1'b1, 1'b1), NO_REQ, NO_RSP);
    add_row(retire_obs(), NO_REQ, NO_RSP);
    end_test('0);
    begin_test(8'd5, '1);
    add_row(fence_state(1'b0, 1'b1, 1'b1), NO_REQ, NO_RSP);
    add_row(retire_obs(), NO_REQ, NO_RSP);
    end_test(viol_bit(mon_pkg::V_FENCEI_NO_INSTR));
    begin_test(8'd6, '1);
    add_row(fence_state(1'b1, 1'b1, 1'b0), NO_REQ, NO_RSP);
    add_row(retire_obs(), NO_REQ, NO_RSP);
    end_test(viol_bit(mon_pkg::V_FENCEI_EARLY_CLEAR));
    begin_test(8'd7, '1);
    add_row(fence_state(1'b1, 1'b1, 1'b1), NO_REQ, NO_RSP);
    add_row(fence_state(1'b1, 1'b1, 1'b1), NO_REQ, NO_RSP);
    add_row(retire_obs(), NO_REQ, NO_RSP);
    end_test(viol_bit(mon_pkg::V_FENCEI_HOLD));
    begin_test(8'd8, '1);
    add_row(fence_state(1'b1, 1'b1, 1'b1), NO_REQ, NO_RSP);
    add_row('0, NO_REQ, NO_RSP);
    end_test(viol_bit(mon_pkg::V_FENCEI_NO_RETIRE));
    // Two in flight, interrupt acknowledge, third accept, then drain
    begin_test(8'd9, '1);
    add_row('0, ACC_RD, NO_RSP);
    add_row('0, ACC_WR, NO_RSP);
    o         = '0;
    o.irq_ack = 1'b1;
    add_row(o, NO_REQ, NO_RSP);
    add_row('0, ACC_RD, NO_RSP);
    add_row('0, NO_REQ, RSP_OK);
    add_row('0, NO_REQ, RSP_OK);
    end_test(viol_bit(mon_pkg::V_IRQ_OUTSTANDING) | viol_bit(mon_pkg::V_OBI_OVERFLOW));
    // Store error with the wrong pending NMI type, then with the right one
    for (int t = 0; t < 2; t++) begin
      begin_test(8'd10 + 8'(t), '1);
      add_row('0, ACC_WR, NO_RSP);
      add_row('0, NO_REQ, RSP_ERR);
      o              = '0;
      o.nmi_pending  = 1'b1;
      o.nmi_is_store = (t == 1);
      add_row(o, NO_REQ, NO_RSP);
      add_row(pc_update(obs_pkg::PC_TRAP_NMI), NO_REQ, NO_RSP);
      end_test((t == 0) ? viol_bit(mon_pkg::V_NMI_TYPE) : '0);
    end
    // Load error, then three or two retirements before the NMI is taken
    for (int t = 0; t < 2; t++) begin
      begin_test(8'd12 + 8'(t), '1);
      add_row('0, ACC_RD, NO_RSP);
      add_row('0, NO_REQ, RSP_ERR);
      o             = retire_obs();
      o.nmi_pending = 1'b1;
      add_row(o, NO_REQ, NO_RSP);
      add_row(retire_obs(), NO_REQ, NO_RSP);
      if (t == 0) begin
        add_row(retire_obs(), NO_REQ, NO_RSP);
      end
      add_row(pc_update(obs_pkg::PC_TRAP_NMI), NO_REQ, NO_RSP);
      end_test((t == 0) ? viol_bit(mon_pkg::V_NMI_LATE) : '0);
    end
    // A retirement with the error lowers the bound to two
    begin_test(8'd14, '1);
    add_row('0, ACC_RD, NO_RSP);
    add_row(retire_obs(), NO_REQ, RSP_ERR);
    o             = retire_obs();
    o.nmi_pending = 1'b1;
    add_row(o, NO_REQ, NO_RSP);
    add_row(retire_obs(), NO_REQ, NO_RSP);
    add_row(pc_update(obs_pkg::PC_TRAP_NMI), NO_REQ, NO_RSP);
    end_test(viol_bit(mon_pkg::V_NMI_LATE));
    // The NMI trap above released the latch so retirements are free again
    begin_test(8'd15, '1);
    repeat (4) add_row(retire_obs(), NO_REQ, NO_RSP);
    end_test('0);
    // Masked fault, two faults in one cycle, and a clear after a fault
    begin_test(8'd16, ~viol_bit(mon_pkg::V_BRANCH_B2B));
    add_row(pc_update(obs_pkg::PC_BRANCH), NO_REQ, NO_RSP);
    add_row(pc_update(obs_pkg::PC_BRANCH), NO_REQ, NO_RSP);
    end_test('0);
    begin_test(8'd17, '1);
    o           = fence_state(1'b0, 1'b1, 1'b1);
    o.pc_set    = 1'b1;
    o.pc_mux    = obs_pkg::PC_MRET;
    o.csr_we_wb = 1'b1;
    add_row(o, NO_REQ, NO_RSP);
    add_row(retire_obs(), NO_REQ, NO_RSP);
    end_test(viol_bit(mon_pkg::V_XRET_CSR) | viol_bit(mon_pkg::V_FENCEI_NO_INSTR));
    begin_test(8'd18, '1);
    add_row(pc_update(obs_pkg::PC_BRANCH), NO_REQ, NO_RSP);
    add_row(pc_update(obs_pkg::PC_BRANCH), NO_REQ, NO_RSP);
    clear_row();
    end_test('0);
    // Three retirements after a load error, one of them in debug mode
    begin_test(8'd19, '1);
    add_row('0, ACC_RD, NO_RSP);
    add_row('0, NO_REQ, RSP_ERR);
    o             = retire_obs();
    o.nmi_pending = 1'b1;
    add_row(o, NO_REQ, NO_RSP);
    o            = retire_obs();
    o.debug_mode = 1'b1;
    add_row(o, NO_REQ, NO_RSP);
    add_row(retire_obs(), NO_REQ, NO_RSP);
    add_row(pc_update(obs_pkg::PC_TRAP_NMI), NO_REQ, NO_RSP);
    end_test('0);
  endtask

  ////////////////////////////////////////////////////////////
  // Drive loop
  ////////////////////////////////////////////////////////////

  // Write enable is a don't care unless the request is accepted
  task automatic drive_row(input stim_row_t r);
    logic [31:0] rnd;
    rnd      = $urandom();
    obs      = r.obs;
    bus_req  = r.req;
    bus_resp = r.resp;
    en_mask  = r.en_mask;
    clear    = r.clear;
    if (!(r.req.req && r.req.gnt)) begin
      bus_req.we = rnd[0];
    end
  endtask

  initial begin
    int waits;
    clk       = 1'b0;
    rst_n     = 1'b0;
    obs       = '0;
    bus_req   = '0;
    bus_resp  = '0;
    en_mask   = '1;
    clear     = 1'b0;
    check_req = 1'b0;
    check_id  = '0;
    check_exp = '0;
    n_tests   = 0;
    timed_out = 1'b0;
    void'($urandom(32'h3d51c744));
    build_table();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < stim_q.size() && !timed_out; i++) begin
      @(negedge clk);
      drive_row(stim_q[i]);
      if (stim_q[i].last) begin
        // Inputs stay idle while the checker compares the settled flags
        @(negedge clk);
        check_id  = stim_q[i].test_id;
        check_exp = stim_q[i].exp;
        check_req = 1'b1;
        waits     = 0;
        @(posedge clk);
        while (!check_done && waits < DONE_LIMIT) begin
          @(posedge clk);
          waits++;
        end
        if (!check_done) begin
          $display("Timeout: the checker gave no answer for test %0d within %0d cycles",
                   check_id, DONE_LIMIT);
          timed_out = 1'b1;
        end
        @(negedge clk);
        check_req = 1'b0;
      end
    end

    $display("Tests: %0d run, %0d passed, %0d failed", n_tests, pass_cnt, fail_cnt);
    if (!timed_out && fail_cnt == 0 && pass_cnt == n_tests) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: src.f
common/obs_pkg.sv
common/mon_pkg.sv
source/pc_seq_check.sv
source/fencei_check.sv
bus_err/bus_err_tracker.sv
bus_err/nmi_retire_check.sv
source/viol_log.sv
source/ctrl_monitor_top.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: Makefile
# Verilator build and run for the controller monitor testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_top
FILELIST  := src.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := TEST RESULT: PASS

SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
